// ==== Bender.yml ====
package:
  name: ctr_apb

sources:
  - include_dirs:
      - source
    files:
      - source/ctr_pkg.sv
      - source/ctr_lfsr_seed.sv
      - source/ctr_count_core.sv
      - source/ctr_event_capture.sv
      - source/ctr_apb_decode.sv
      - source/ctr_apb_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/ctr_tb.sv

// ==== flist.f ====
+incdir+source
source/ctr_pkg.sv
source/ctr_lfsr_seed.sv
source/ctr_count_core.sv
source/ctr_event_capture.sv
source/ctr_apb_decode.sv
source/ctr_apb_top.sv
verification/ctr_tb.sv

// ==== source/ctr_apb_decode.sv ====
/* Zero-wait APB slave, pready tied high and pslverr never raised.
   Unmapped offsets read 0; CMD is write-only and reads 0 */
`timescale 1ns/100ps
`include "ctr_cfg.svh"

module ctr_apb_decode (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`CTR_ADDR_W-1:0] paddr,
    input  logic [31:0]            pwdata,
    input  logic [`CTR_WIDTH-1:0]  count,
    input  logic                   ovf_flag,
    input  logic                   unf_flag,
    input  logic [15:0]            wraps,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   enable,
    output logic                   down,
    output ctr_pkg::ctr_op_e       op,
    output logic                   op_valid,
    output logic [`CTR_WIDTH-1:0]  load_value,
    output logic                   clear_ovf,
    output logic                   clear_unf
);

    logic wr_access;
    logic rd_access;

    assign wr_access = psel && penable && pwrite;  // Write lands on this edge
    assign rd_access = psel && !pwrite;

    assign pready  = 1'b1;
    assign pslverr = 1'b0;

    // Control levels and one-cycle command/clear pulses
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            enable    <= 1'b0;
            down      <= 1'b0;
            op_valid  <= 1'b0;
            clear_ovf <= 1'b0;
            clear_unf <= 1'b0;
        end else begin
            op_valid  <= wr_access && (paddr == `CTR_REG_CMD);
            clear_ovf <= wr_access && (paddr == `CTR_REG_STATUS) && pwdata[0];
            clear_unf <= wr_access && (paddr == `CTR_REG_STATUS) && pwdata[1];
            if (wr_access && (paddr == `CTR_REG_CTRL)) begin
                enable <= pwdata[0];
                down   <= pwdata[1];   // 1 counts down
            end
        end
    end

    // Payload only, qualified by op_valid or by the core's command
    always_ff @(posedge clk) begin
        if (wr_access && (paddr == `CTR_REG_LOAD)) begin
            load_value <= pwdata[`CTR_WIDTH-1:0];
        end
        if (wr_access && (paddr == `CTR_REG_CMD)) begin
            op <= ctr_pkg::ctr_op_e'(pwdata[2:0]);
        end
    end

    // Read mux, all sources registered
    always_comb begin
        prdata = 32'd0;
        if (rd_access) begin
            case (paddr)
                `CTR_REG_CTRL:   prdata = {30'd0, down, enable};
                `CTR_REG_LOAD:   prdata = {{(32-`CTR_WIDTH){1'b0}}, load_value};
                `CTR_REG_COUNT:  prdata = {{(32-`CTR_WIDTH){1'b0}}, count};
                `CTR_REG_STATUS: prdata = {30'd0, unf_flag, ovf_flag};
                `CTR_REG_WRAPS:  prdata = {16'd0, wraps};
                default:         prdata = 32'd0;
            endcase
        end
    end

endmodule

// ==== source/ctr_apb_top.sv ====
/* Counter/timer peripheral on a zero-wait APB slave port.
   pclk is clk; irq stays high while either wrap flag is set */
`timescale 1ns/100ps
`include "ctr_cfg.svh"

module ctr_apb_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`CTR_ADDR_W-1:0] paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   irq
);

    logic                  enable;
    logic                  down;
    ctr_pkg::ctr_op_e      op;
    logic                  op_valid;
    logic [`CTR_WIDTH-1:0] load_value;
    logic [`CTR_WIDTH-1:0] count;
    logic                  ovf_pulse;
    logic                  unf_pulse;
    logic                  ovf_flag;
    logic                  unf_flag;
    logic [15:0]           wraps;
    logic                  clear_ovf;
    logic                  clear_unf;

    ctr_apb_decode decode_i (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .count      (count),
        .ovf_flag   (ovf_flag),
        .unf_flag   (unf_flag),
        .wraps      (wraps),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .enable     (enable),
        .down       (down),
        .op         (op),
        .op_valid   (op_valid),
        .load_value (load_value),
        .clear_ovf  (clear_ovf),
        .clear_unf  (clear_unf)
    );

    ctr_count_core core_i (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .down       (down),
        .op         (op),
        .op_valid   (op_valid),
        .load_value (load_value),
        .count      (count),
        .ovf_pulse  (ovf_pulse),
        .unf_pulse  (unf_pulse)
    );

    ctr_event_capture capture_i (
        .clk        (clk),
        .rst        (rst),
        .ovf_pulse  (ovf_pulse),
        .unf_pulse  (unf_pulse),
        .clear_ovf  (clear_ovf),
        .clear_unf  (clear_unf),
        .ovf_flag   (ovf_flag),
        .unf_flag   (unf_flag),
        .wraps      (wraps),
        .irq        (irq)
    );

endmodule

// ==== source/ctr_cfg.svh ====
/* Widths, APB register offsets and LFSR seed for the counter peripheral.
   Offsets assume an 8-bit paddr; the LFSR taps are fixed for a 16-bit counter */
`ifndef CTR_CFG_SVH
`define CTR_CFG_SVH

`define CTR_WIDTH 16            // Counter and load width
`define CTR_ADDR_W 8            // APB address width
`define CTR_SEED 16'hFF42       // LFSR value after reset

// Register map, byte offsets
`define CTR_REG_CTRL 8'h00      // [0] enable, [1] down
`define CTR_REG_CMD 8'h04       // Write-only opcode
`define CTR_REG_LOAD 8'h08      // Load value
`define CTR_REG_COUNT 8'h0C     // Read-only
`define CTR_REG_STATUS 8'h10    // [0] ovf, [1] unf, write 1 to clear
`define CTR_REG_WRAPS 8'h14     // Read-only, saturates

`endif

// ==== source/ctr_count_core.sv ====
/* Counter execute stage. Commands are taken only in IDLE and dropped
   otherwise; count output lags the internal counter by one cycle */
`timescale 1ns/100ps
`include "ctr_cfg.svh"

module ctr_count_core (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  enable,
    input  logic                  down,
    input  ctr_pkg::ctr_op_e      op,
    input  logic                  op_valid,
    input  logic [`CTR_WIDTH-1:0] load_value,
    output logic [`CTR_WIDTH-1:0] count,
    output logic                  ovf_pulse,
    output logic                  unf_pulse
);

    ctr_pkg::ctr_state_e   state;
    logic [`CTR_WIDTH-1:0] counter;
    logic [`CTR_WIDTH-1:0] pattern;
    logic [`CTR_WIDTH-1:0] step_value;
    logic                  step_wrap;
    logic                  cmd_take;
    logic                  seed_req;

    // One step in the current direction, shared by STEP and free counting
    always_comb begin
        if (down) begin
            step_value = counter - 1'b1;
            step_wrap  = (counter == '0);
        end else begin
            step_value = counter + 1'b1;
            step_wrap  = (counter == '1);
        end
    end

    assign cmd_take = op_valid && (state == ctr_pkg::IDLE);
    assign seed_req = cmd_take && (op == ctr_pkg::SEED);  // LFSR moves after this use

    ctr_lfsr_seed lfsr_i (
        .clk      (clk),
        .rst      (rst),
        .seed_req (seed_req),
        .pattern  (pattern)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ctr_pkg::IDLE;
            counter   <= '0;
            ovf_pulse <= 1'b0;
            unf_pulse <= 1'b0;
        end else begin
            ovf_pulse <= 1'b0;  // Pulses last one cycle
            unf_pulse <= 1'b0;
            case (state)
                ctr_pkg::IDLE: begin
                    if (cmd_take) begin
                        case (op)
                            ctr_pkg::LOAD: counter <= load_value;
                            ctr_pkg::SEED: counter <= pattern;
                            ctr_pkg::STEP: begin
                                counter <= step_value;
                                if (step_wrap) begin
                                    ovf_pulse <= !down;
                                    unf_pulse <= down;
                                    state     <= down ? ctr_pkg::UNDERFLOW
                                                      : ctr_pkg::OVERFLOW;
                                end
                            end
                            default: ;  // NOP and unused codes
                        endcase
                    end else if (enable) begin
                        state <= ctr_pkg::COUNT;
                    end
                end
                ctr_pkg::COUNT: begin
                    if (enable) begin
                        counter <= step_value;
                        if (step_wrap) begin
                            ovf_pulse <= !down;
                            unf_pulse <= down;
                            state     <= down ? ctr_pkg::UNDERFLOW : ctr_pkg::OVERFLOW;
                        end
                    end else begin
                        state <= ctr_pkg::IDLE;
                    end
                end
                ctr_pkg::OVERFLOW:  state <= ctr_pkg::IDLE;
                ctr_pkg::UNDERFLOW: state <= ctr_pkg::IDLE;
                default:            state <= ctr_pkg::IDLE;
            endcase
        end
    end

    // Registered view of the counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else begin
            count <= counter;
        end
    end

endmodule

// ==== source/ctr_event_capture.sv ====
/* Sticky wrap flags, saturating wrap counter and interrupt.
   A clear in the same cycle as a new pulse leaves the flag set */
`timescale 1ns/100ps

module ctr_event_capture (
    input  logic        clk,
    input  logic        rst,
    input  logic        ovf_pulse,
    input  logic        unf_pulse,
    input  logic        clear_ovf,
    input  logic        clear_unf,
    output logic        ovf_flag,
    output logic        unf_flag,
    output logic [15:0] wraps,
    output logic        irq
);

    logic ovf_next;
    logic unf_next;

    // Set wins over clear
    assign ovf_next = ovf_pulse || (ovf_flag && !clear_ovf);
    assign unf_next = unf_pulse || (unf_flag && !clear_unf);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ovf_flag <= 1'b0;
            unf_flag <= 1'b0;
            irq      <= 1'b0;
        end else begin
            ovf_flag <= ovf_next;
            unf_flag <= unf_next;
            irq      <= ovf_next || unf_next;  // Tracks the flags with no extra lag
        end
    end

    // Wrap count, holds at all ones
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wraps <= 16'd0;
        end else if ((ovf_pulse || unf_pulse) && (wraps != 16'hFFFF)) begin
            wraps <= wraps + 16'd1;
        end
    end

endmodule

// ==== source/ctr_lfsr_seed.sv ====
/* Fibonacci LFSR, taps 15/11/7/3, advancing only on seed_req.
   Pattern is valid in the same cycle as the request */
`timescale 1ns/100ps
`include "ctr_cfg.svh"

module ctr_lfsr_seed (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  seed_req,
    output logic [`CTR_WIDTH-1:0] pattern
);

    logic feedback;

    assign feedback = pattern[15] ^ pattern[11] ^ pattern[7] ^ pattern[3];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pattern <= `CTR_SEED;
        end else if (seed_req) begin
            // Shift left, new bit enters at 0
            pattern <= {pattern[`CTR_WIDTH-2:0], feedback};
        end
    end

endmodule

// ==== source/ctr_pkg.sv ====
/* Shared types for the counter peripheral.
   Opcode values are what software writes to the CMD register */
package ctr_pkg;

    // Counter FSM
    typedef enum logic [1:0] {
        IDLE      = 2'd0,
        COUNT     = 2'd1,
        OVERFLOW  = 2'd2,   // One-cycle recovery after an up wrap
        UNDERFLOW = 2'd3    // One-cycle recovery after a down wrap
    } ctr_state_e;

    // CMD register opcodes
    typedef enum logic [2:0] {
        NOP  = 3'd0,
        LOAD = 3'd1,    // Copy LOAD register into the counter
        SEED = 3'd2,    // Copy LFSR pattern, then advance LFSR
        STEP = 3'd3     // Move by one in the current direction
    } ctr_op_e;

endpackage

// ==== verification/ctr_tb.sv ====
/* Testbench for the APB counter peripheral. Expected reads come from a model
   that only tracks the counter while it is stopped; free counting is bounded */
`timescale 1ns/100ps
`include "ctr_cfg.svh"

module ctr_tb;

    localparam int TBL_MAX = 128;

    // Table operations
    localparam logic [2:0] T_WR   = 3'd0;
    localparam logic [2:0] T_RD   = 3'd1;  // Exact compare
    localparam logic [2:0] T_RDLE = 3'd2;  // Value at most the expected one
    localparam logic [2:0] T_POLL = 3'd3;  // Read until (data & mask) == expected
    localparam logic [2:0] T_IRQ  = 3'd4;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic        irq;

    logic [2:0]  tbl_op   [TBL_MAX];
    logic [7:0]  tbl_addr [TBL_MAX];
    logic [31:0] tbl_data [TBL_MAX];
    logic [31:0] tbl_exp  [TBL_MAX];
    int          tbl_test [TBL_MAX];
    int          tbl_len;
    int          cur_test;

    // Reference model state
    logic [15:0] m_count;
    logic [15:0] m_lfsr;
    logic [15:0] m_load;
    logic [15:0] m_wraps;
    logic        m_enable;
    logic        m_down;
    logic        m_ovf;
    logic        m_unf;

    integer seed;
    int     errors;
    int     checks;
    int     bus_errors;   // Handshake results since the last table entry
    int     bus_checks;
    int     cycles;
    int     cycle_limit;

    ctr_apb_top dut_i (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .irq     (irq)
    );

    always #2 clk = ~clk;

    // Watchdog
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Test timed out after %0d cycles", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic string reg_name(logic [7:0] addr);
        case (addr)
            `CTR_REG_CTRL:   return "CTRL";
            `CTR_REG_CMD:    return "CMD";
            `CTR_REG_LOAD:   return "LOAD";
            `CTR_REG_COUNT:  return "COUNT";
            `CTR_REG_STATUS: return "STATUS";
            `CTR_REG_WRAPS:  return "WRAPS";
            default:         return "UNMAPPED";
        endcase
    endfunction

    function automatic string test_name(int id);
        case (id)
            0:       return "reset state";
            1:       return "load and step";
            2:       return "seed patterns";
            3:       return "wrap by step";
            4:       return "flag clear";
            default: return "free-running count";
        endcase
    endfunction

    function automatic logic [31:0] op_word(ctr_pkg::ctr_op_e op);
        return {29'd0, op};
    endfunction

    function automatic logic [31:0] model_read(logic [7:0] addr);
        case (addr)
            `CTR_REG_CTRL:   return {30'd0, m_down, m_enable};
            `CTR_REG_LOAD:   return {16'd0, m_load};
            `CTR_REG_COUNT:  return {16'd0, m_count};
            `CTR_REG_STATUS: return {30'd0, m_unf, m_ovf};
            `CTR_REG_WRAPS:  return {16'd0, m_wraps};
            default:         return 32'd0;
        endcase
    endfunction

    task automatic add_entry(logic [2:0] op, logic [7:0] addr, logic [31:0] data,
                             logic [31:0] exp);
        tbl_op[tbl_len]   = op;
        tbl_addr[tbl_len] = addr;
        tbl_data[tbl_len] = data;
        tbl_exp[tbl_len]  = exp;
        tbl_test[tbl_len] = cur_test;
        tbl_len = tbl_len + 1;
    endtask

    // Command effect while the counter is stopped
    task automatic model_cmd(logic [2:0] code);
        logic wrapped;
        wrapped = 1'b0;
        case (code)
            ctr_pkg::LOAD: m_count = m_load;
            ctr_pkg::SEED: begin
                m_count = m_lfsr;
                m_lfsr  = {m_lfsr[14:0], m_lfsr[15] ^ m_lfsr[11] ^ m_lfsr[7] ^ m_lfsr[3]};
            end
            ctr_pkg::STEP: begin
                if (m_down) begin
                    wrapped = (m_count == 16'h0000);
                    m_unf   = m_unf | wrapped;
                    m_count = m_count - 16'd1;
                end else begin
                    wrapped = (m_count == 16'hFFFF);
                    m_ovf   = m_ovf | wrapped;
                    m_count = m_count + 16'd1;
                end
            end
            default: ;
        endcase
        if (wrapped && m_wraps != 16'hFFFF) begin
            m_wraps = m_wraps + 16'd1;
        end
    endtask

    task automatic plan_write(logic [7:0] addr, logic [31:0] data);
        add_entry(T_WR, addr, data, 32'd0);
        case (addr)
            `CTR_REG_CTRL: begin
                m_enable = data[0];
                m_down   = data[1];
            end
            `CTR_REG_LOAD:   m_load = data[15:0];
            `CTR_REG_CMD:    model_cmd(data[2:0]);
            `CTR_REG_STATUS: begin
                m_ovf = m_ovf & !data[0];  // Write 1 to clear
                m_unf = m_unf & !data[1];
            end
            default: ;
        endcase
    endtask

    task automatic plan_read(logic [7:0] addr);
        add_entry(T_RD, addr, 32'd0, model_read(addr));
    endtask

    task automatic plan_irq();
        add_entry(T_IRQ, 8'd0, 32'd0, {31'd0, m_ovf | m_unf});
    endtask

    task automatic build_table();
        logic [15:0] value;
        int          i;
        m_count  = 16'd0;
        m_lfsr   = `CTR_SEED;
        m_load   = 16'd0;
        m_wraps  = 16'd0;
        m_enable = 1'b0;
        m_down   = 1'b0;
        m_ovf    = 1'b0;
        m_unf    = 1'b0;
        tbl_len  = 0;
        cur_test = 0;
        plan_read(`CTR_REG_COUNT);
        plan_read(`CTR_REG_STATUS);
        plan_read(`CTR_REG_WRAPS);
        plan_irq();
        cur_test = 1;
        for (i = 0; i < 4; i++) begin
            value = $random(seed);
            plan_write(`CTR_REG_LOAD, {16'd0, value});
            plan_write(`CTR_REG_CMD, op_word(ctr_pkg::LOAD));
            plan_read(`CTR_REG_COUNT);
        end
        plan_read(`CTR_REG_LOAD);
        plan_write(`CTR_REG_CMD, op_word(ctr_pkg::STEP));
        plan_read(`CTR_REG_COUNT);
        plan_write(`CTR_REG_CTRL, 32'h2);   // Down, stopped
        plan_read(`CTR_REG_CTRL);
        plan_write(`CTR_REG_CMD, op_word(ctr_pkg::STEP));
        plan_write(`CTR_REG_CMD, op_word(ctr_pkg::STEP));
        plan_read(`CTR_REG_COUNT);
        plan_write(`CTR_REG_CTRL, 32'h0);
        cur_test = 2;
        for (i = 0; i < 4; i++) begin
            plan_write(`CTR_REG_CMD, op_word(ctr_pkg::SEED));
            plan_read(`CTR_REG_COUNT);
        end
        cur_test = 3;
        plan_write(`CTR_REG_LOAD, 32'hFFFF);
        plan_write(`CTR_REG_CMD, op_word(ctr_pkg::LOAD));
        plan_write(`CTR_REG_CMD, op_word(ctr_pkg::STEP));
        plan_read(`CTR_REG_COUNT);
        plan_read(`CTR_REG_STATUS);
        plan_irq();
        plan_read(`CTR_REG_WRAPS);
        plan_write(`CTR_REG_CTRL, 32'h2);
        plan_write(`CTR_REG_LOAD, 32'h0);
        plan_write(`CTR_REG_CMD, op_word(ctr_pkg::LOAD));
        plan_write(`CTR_REG_CMD, op_word(ctr_pkg::STEP));
        plan_read(`CTR_REG_COUNT);
        plan_read(`CTR_REG_STATUS);
        plan_read(`CTR_REG_WRAPS);
        plan_write(`CTR_REG_CTRL, 32'h0);
        cur_test = 4;
        plan_write(`CTR_REG_STATUS, 32'h1);
        plan_read(`CTR_REG_STATUS);
        plan_irq();
        plan_write(`CTR_REG_STATUS, 32'h2);
        plan_read(`CTR_REG_STATUS);
        plan_irq();
        plan_read(`CTR_REG_WRAPS);
        cur_test = 5;
        plan_write(`CTR_REG_LOAD, 32'hFFFA);
        plan_write(`CTR_REG_CMD, op_word(ctr_pkg::LOAD));
        plan_read(`CTR_REG_COUNT);
        plan_write(`CTR_REG_CTRL, 32'h1);   // Count up
        add_entry(T_POLL, `CTR_REG_STATUS, 32'h1, 32'h1);
        plan_write(`CTR_REG_CTRL, 32'h0);
        m_ovf   = 1'b1;                     // One overflow while free running
        m_wraps = m_wraps + 16'd1;
        add_entry(T_RDLE, `CTR_REG_COUNT, 32'd0, 32'd8);
        plan_read(`CTR_REG_STATUS);
        plan_read(`CTR_REG_WRAPS);
    endtask

    // Zero-wait slave, so every access phase shows pready high and no error
    task automatic check_handshake();
        bus_checks = bus_checks + 1;
        assert (pready === 1'b1) else begin
            $display("** Error at %t: pready expected 1, got %b", $realtime, pready);
            bus_errors = bus_errors + 1;
        end
        assert (pslverr === 1'b0) else begin
            $display("** Error at %t: pslverr expected 0, got %b", $realtime, pslverr);
            bus_errors = bus_errors + 1;
        end
    endtask

    task automatic apb_write(logic [7:0] addr, logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        check_handshake();
        @(posedge clk);                     // Write lands on this edge
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        data = prdata;                      // Mid access phase
        check_handshake();
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic run_table();
        logic [31:0] rdata;
        int          i;
        int          test_errors;
        int          test_checks;
        test_errors = 0;
        test_checks = 0;
        for (i = 0; i < tbl_len; i++) begin
            case (tbl_op[i])
                T_WR: apb_write(tbl_addr[i], tbl_data[i]);
                T_RD: begin
                    apb_read(tbl_addr[i], rdata);
                    test_checks++;
                    assert (rdata === tbl_exp[i]) else begin
                        $display("** Error at %t: %s expected 0x%08h, got 0x%08h", $realtime,
                                 reg_name(tbl_addr[i]), tbl_exp[i], rdata);
                        test_errors++;
                    end
                end
                T_RDLE: begin
                    apb_read(tbl_addr[i], rdata);
                    test_checks++;
                    assert (rdata <= tbl_exp[i]) else begin
                        $display("** Error at %t: %s expected at most 0x%08h, got 0x%08h",
                                 $realtime, reg_name(tbl_addr[i]), tbl_exp[i], rdata);
                        test_errors++;
                    end
                end
                T_POLL: begin
                    do begin
                        apb_read(tbl_addr[i], rdata);
                    end while ((rdata & tbl_data[i]) !== tbl_exp[i]);
                    test_checks++;
                end
                default: begin
                    @(negedge clk);
                    test_checks++;
                    assert (irq === tbl_exp[i][0]) else begin
                        $display("** Error at %t: irq expected %b, got %b", $realtime,
                                 tbl_exp[i][0], irq);
                        test_errors++;
                    end
                end
            endcase
            test_errors = test_errors + bus_errors;
            test_checks = test_checks + bus_checks;
            bus_errors  = 0;
            bus_checks  = 0;
            if (i == tbl_len - 1 || tbl_test[i + 1] != tbl_test[i]) begin
                $display("Test %0d (%s): %0d checks, %0d errors, core in %s", tbl_test[i] + 1,
                         test_name(tbl_test[i]), test_checks, test_errors,
                         dut_i.core_i.state.name());
                errors      = errors + test_errors;
                checks      = checks + test_checks;
                test_errors = 0;
                test_checks = 0;
            end
        end
    endtask

    initial begin
        $timeformat(-9, 1, " ns", 0);
        seed       = 32'h3bed_90d5;
        errors     = 0;
        checks     = 0;
        bus_errors = 0;
        bus_checks = 0;
        cycles     = 0;
        clk        = 1'b0;
        rst        = 1'b1;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = 8'd0;
        pwdata     = 32'd0;
        build_table();
        cycle_limit = tbl_len * 10 + 200;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        run_table();
        $display("Summary: %0d table entries, %0d checks, %0d errors", tbl_len, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
